/* Makefile */
VERILATOR ?= verilator
TOP       ?= proc16Tb
FILELIST  ?= proc16.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert --x-initial 0 -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)

/* design/decode.sv */
// Instruction decode stage
module decode (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               ifValid,
    input  proc16Pkg::instrT                   ifInstr,
    input  logic                               ifHalt,
    input  logic                               wbValid,    // Writeback return path
    input  logic                               wbRegWrite,
    input  logic [proc16Pkg::regAddrWidth-1:0] wbDest,
    input  logic [proc16Pkg::dataWidth-1:0]    wbData,
    output logic                               exValid,
    output logic                               exHalt,
    output logic [proc16Pkg::dataWidth-1:0]    rsVal,
    output logic [proc16Pkg::dataWidth-1:0]    rtVal,     // Store data on ST
    output logic [proc16Pkg::dataWidth-1:0]    immExt,
    output logic                               aluSrcImm,
    output logic [1:0]                         aluFunct,
    output logic                               memRead,
    output logic                               memWrite,
    output logic                               regWrite,
    output logic [proc16Pkg::regAddrWidth-1:0] destReg,
    output logic                               err        // Sticky illegal opcode
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int dw = proc16Pkg::dataWidth;
    localparam int aw = proc16Pkg::regAddrWidth;

    logic [dw-1:0] regs [2**aw]; // Register file
    logic [aw-1:0] rsAddr;
    logic [aw-1:0] rtAddr;
    logic [aw-1:0] destSel;
    logic [dw-1:0] rsRead;
    logic [dw-1:0] rtRead;
    logic [dw-1:0] immSel;
    logic [1:0]    functSel;
    logic          srcImm;
    logic          rdMem;
    logic          wrMem;
    logic          wrReg;
    logic          illegal;
    logic          slotValid;
    logic          wbHit;

    assign slotValid = ifValid && !err;                          // Drop slots once err is up
    assign rsAddr    = ifInstr.r.rs;                             // Same bits in both views
    assign rtAddr    = ifInstr.r.rt;                             // Also i.rd, the ST source
    assign immSel    = {{(dw-5){ifInstr.i.imm[4]}}, ifInstr.i.imm}; // Sign extend
    assign wbHit     = wbValid && wbRegWrite;

    // Same-cycle write passes through to the reads
    assign rsRead = (wbHit && wbDest == rsAddr) ? wbData : regs[rsAddr];
    assign rtRead = (wbHit && wbDest == rtAddr) ? wbData : regs[rtAddr];

    always_ff @(posedge clk) begin
        if (wbHit) begin
            regs[wbDest] <= wbData;
        end
    end

    // Control decode, R or I view chosen by opcode
    always_comb begin
        destSel  = ifInstr.r.rd;
        functSel = proc16Pkg::fnAdd; // Address math is an add
        srcImm   = 1'b0;
        rdMem    = 1'b0;
        wrMem    = 1'b0;
        wrReg    = 1'b0;
        illegal  = 1'b0;
        case (ifInstr.r.opcode)
            proc16Pkg::opNop, proc16Pkg::opHalt: illegal = 1'b0; // Halt rides on ifHalt
            proc16Pkg::opAlu: begin
                wrReg    = 1'b1;
                functSel = ifInstr.r.funct;
            end
            proc16Pkg::opAddi: begin
                wrReg   = 1'b1;
                srcImm  = 1'b1;
                destSel = ifInstr.i.rd;
            end
            proc16Pkg::opLd: begin
                wrReg   = 1'b1;
                rdMem   = 1'b1;
                srcImm  = 1'b1;
                destSel = ifInstr.i.rd;
            end
            proc16Pkg::opSt: begin
                wrMem  = 1'b1;
                srcImm = 1'b1; // Store value arrives on rtVal
            end
            default: illegal = 1'b1;   // Behaves as NOP
        endcase
    end

    // ID/EX control
    always_ff @(posedge clk) begin
        if (reset) begin
            exValid   <= 1'b0;
            exHalt    <= 1'b0;
            aluSrcImm <= 1'b0;
            aluFunct  <= proc16Pkg::fnAdd;
            memRead   <= 1'b0;
            memWrite  <= 1'b0;
            regWrite  <= 1'b0;
            err       <= 1'b0;
        end else begin
            exValid   <= slotValid;
            exHalt    <= slotValid && (ifHalt || illegal); // Illegal slot drains like HALT
            aluSrcImm <= srcImm;
            aluFunct  <= functSel;
            memRead   <= slotValid && rdMem;
            memWrite  <= slotValid && wrMem;
            regWrite  <= slotValid && wrReg;
            err       <= err || (slotValid && illegal);
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        rsVal   <= rsRead;
        rtVal   <= rtRead;
        immExt  <= immSel;
        destReg <= destSel;
    end

endmodule

/* design/execute.sv */
// Execute stage
module execute (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               exValid,
    input  logic                               exHalt,
    input  logic [proc16Pkg::dataWidth-1:0]    rsVal,
    input  logic [proc16Pkg::dataWidth-1:0]    rtVal,
    input  logic [proc16Pkg::dataWidth-1:0]    immExt,
    input  logic                               aluSrcImm,
    input  logic [1:0]                         aluFunct,
    input  logic                               memRead,
    input  logic                               memWrite,
    input  logic                               regWrite,
    input  logic [proc16Pkg::regAddrWidth-1:0] destReg,
    output logic                               memValid,
    output logic                               memHalt,
    output logic [proc16Pkg::dataWidth-1:0]    aluOut,    // Result or data address
    output logic [proc16Pkg::dataWidth-1:0]    storeData,
    output logic                               memReadOut,
    output logic                               memWriteOut,
    output logic                               memRegWrite,
    output logic [proc16Pkg::regAddrWidth-1:0] memDest
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [proc16Pkg::dataWidth-1:0] opB;
    logic [proc16Pkg::dataWidth-1:0] result;

    assign opB = aluSrcImm ? immExt : rtVal; // Second operand

    // ALU, wraps modulo 2^16
    always_comb begin
        case (aluFunct)
            proc16Pkg::fnSub: result = rsVal - opB;
            proc16Pkg::fnAnd: result = rsVal & opB;
            proc16Pkg::fnXor: result = rsVal ^ opB;
            default:          result = rsVal + opB; // fnAdd
        endcase
    end

    // EX/MEM control
    always_ff @(posedge clk) begin
        if (reset) begin
            memValid    <= 1'b0;
            memHalt     <= 1'b0;
            memReadOut  <= 1'b0;
            memWriteOut <= 1'b0;
            memRegWrite <= 1'b0;
        end else begin
            memValid    <= exValid;
            memHalt     <= exHalt;
            memReadOut  <= memRead;
            memWriteOut <= memWrite;
            memRegWrite <= regWrite;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        aluOut    <= result;
        storeData <= rtVal;
        memDest   <= destReg;
    end

endmodule

/* design/fetch.sv */
// Instruction fetch stage
module fetch #(
    parameter int imemDepth = 256
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            run,
    input  logic                            stop,      // Decode saw an illegal opcode
    input  logic                            loadWrite,
    input  logic                            loadSel,   // Low selects this memory
    input  logic [7:0]                      loadAddr,
    input  logic [proc16Pkg::dataWidth-1:0] loadData,
    output logic                            ifValid,
    output proc16Pkg::instrT                ifInstr,
    output logic                            ifHalt
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int pcWidth = $clog2(imemDepth);

    logic [proc16Pkg::dataWidth-1:0] imem [imemDepth]; // Program store
    logic [pcWidth-1:0]              pc;
    logic                            haltSeen; // Sticky until reset
    logic                            issue;
    logic                            isHalt;
    proc16Pkg::instrT                fetched;

    assign fetched = imem[pc];                                // Word at PC
    assign isHalt  = fetched.r.opcode == proc16Pkg::opHalt;  // Only fetch decodes HALT
    assign issue   = run && !haltSeen && !stop;              // One slot per cycle

    // Loader port, idle core only
    always_ff @(posedge clk) begin
        if (loadWrite && !loadSel && !run) begin
            imem[loadAddr[pcWidth-1:0]] <= loadData;
        end
    end

    // PC and IF/ID control
    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            haltSeen <= 1'b0;
            ifValid  <= 1'b0;
            ifHalt   <= 1'b0;
        end else begin
            ifValid <= issue;           // Bubble when not issuing
            ifHalt  <= issue && isHalt;
            if (issue) begin
                pc       <= pc + 1'b1;  // Wraps at depth
                haltSeen <= isHalt;     // Nothing issues after HALT
            end
        end
    end

    always_ff @(posedge clk) begin
        ifInstr <= fetched; // IF/ID payload
    end

endmodule

/* design/memory.sv */
// Data memory and writeback select stage
module memory #(
    parameter int dmemDepth = 256
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               run,
    input  logic                               memValid,
    input  logic                               memHalt,
    input  logic [proc16Pkg::dataWidth-1:0]    aluOut,
    input  logic [proc16Pkg::dataWidth-1:0]    storeData,
    input  logic                               memReadOut,
    input  logic                               memWriteOut,
    input  logic                               memRegWrite,
    input  logic [proc16Pkg::regAddrWidth-1:0] memDest,
    input  logic                               loadWrite,
    input  logic                               loadSel,   // High selects this memory
    input  logic [7:0]                         loadAddr,
    input  logic [proc16Pkg::dataWidth-1:0]    loadData,
    input  logic [7:0]                         dbgAddr,
    output logic [proc16Pkg::dataWidth-1:0]    dbgData,   // Combinational peek
    output logic                               wbValid,
    output logic                               wbRegWrite,
    output logic [proc16Pkg::regAddrWidth-1:0] wbDest,
    output logic [proc16Pkg::dataWidth-1:0]    wbData,
    output logic                               halted     // Sticky
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int addrWidth = $clog2(dmemDepth);

    logic [proc16Pkg::dataWidth-1:0] dmem [dmemDepth];
    logic [proc16Pkg::dataWidth-1:0] readWord;
    logic                            storeWrite;
    logic                            loadAccept;
    logic                            wbHalt;

    assign storeWrite = memValid && memWriteOut;          // Core store
    assign loadAccept = loadWrite && loadSel && !run;    // Loader, idle only
    assign readWord   = dmem[aluOut[addrWidth-1:0]];     // Low address bits
    assign dbgData    = dmem[dbgAddr[addrWidth-1:0]];

    always_ff @(posedge clk) begin
        if (storeWrite) begin
            dmem[aluOut[addrWidth-1:0]] <= storeData;
        end else if (loadAccept) begin
            dmem[loadAddr[addrWidth-1:0]] <= loadData;
        end
    end

    // MEM/WB control and halt latch
    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid    <= 1'b0;
            wbRegWrite <= 1'b0;
            wbHalt     <= 1'b0;
            halted     <= 1'b0;
        end else begin
            wbValid    <= memValid;
            wbRegWrite <= memRegWrite;
            wbHalt     <= memValid && memHalt;
            halted     <= halted || (wbValid && wbHalt); // Flag leaving MEM/WB
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk) begin
        wbDest <= memDest;
        wbData <= memReadOut ? readWord : aluOut; // Load or ALU result
    end

endmodule

/* design/proc16.sv */
// proc16 pipelined core
module proc16 #(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            run,
    input  logic                            loadWrite,
    input  logic                            loadSel,  // 0 imem, 1 dmem
    input  logic [7:0]                      loadAddr,
    input  logic [proc16Pkg::dataWidth-1:0] loadData,
    input  logic [7:0]                      dbgAddr,
    output logic [proc16Pkg::dataWidth-1:0] dbgData,
    output logic                            halted,
    output logic                            err
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int dw = proc16Pkg::dataWidth;
    localparam int aw = proc16Pkg::regAddrWidth;

    // IF/ID
    logic             ifValid;
    proc16Pkg::instrT ifInstr;
    logic             ifHalt;

    // ID/EX
    logic          exValid;
    logic          exHalt;
    logic [dw-1:0] rsVal;
    logic [dw-1:0] rtVal;
    logic [dw-1:0] immExt;
    logic          aluSrcImm;
    logic [1:0]    aluFunct;
    logic          memRead;
    logic          memWrite;
    logic          regWrite;
    logic [aw-1:0] destReg;

    // EX/MEM
    logic          memValid;
    logic          memHalt;
    logic [dw-1:0] aluOut;
    logic [dw-1:0] storeData;
    logic          memReadOut;
    logic          memWriteOut;
    logic          memRegWrite;
    logic [aw-1:0] memDest;

    // MEM/WB back to the register file
    logic          wbValid;
    logic          wbRegWrite;
    logic [aw-1:0] wbDest;
    logic [dw-1:0] wbData;

    // Stage ports share names with the wires above
    fetch #(.imemDepth(imemDepth)) fetchStage (.*, .stop(err)); // err stops issue
    decode decodeStage (.*);
    execute executeStage (.*);
    memory #(.dmemDepth(dmemDepth)) memoryStage (.*);

endmodule

/* design/proc16Pkg.sv */
// proc16 shared definitions
package proc16Pkg;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int dataWidth    = 16; // Machine word
    localparam int regAddrWidth = 3;  // Eight registers

    // Opcodes, top five bits of every instruction
    localparam logic [4:0] opHalt = 5'b00000; // Stop fetch, drain pipe
    localparam logic [4:0] opNop  = 5'b00001; // Bubble
    localparam logic [4:0] opAddi = 5'b01000; // rd = rs + sext(imm)
    localparam logic [4:0] opSt   = 5'b10000; // mem[rs + sext(imm)] = rd
    localparam logic [4:0] opLd   = 5'b10001; // rd = mem[rs + sext(imm)]
    localparam logic [4:0] opAlu  = 5'b11011; // rd = rs op rt

    // ALU function select, R view only
    localparam logic [1:0] fnAdd = 2'b00;
    localparam logic [1:0] fnSub = 2'b01; // rs minus rt
    localparam logic [1:0] fnXor = 2'b10;
    localparam logic [1:0] fnAnd = 2'b11;

    // One instruction word, two field layouts
    typedef union packed {
        struct packed {
            logic [4:0]              opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [regAddrWidth-1:0] rd;
            logic [1:0]              funct;
        } r; // Register ALU form
        struct packed {
            logic [4:0]              opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rd;  // Store source on ST
            logic [4:0]              imm; // Signed
        } i; // Immediate, load and store form
    } instrT;

endpackage

/* proc16.f */
design/proc16Pkg.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/memory.sv
design/proc16.sv
testbench/proc16_assert.sv
testbench/proc16Tb.sv

/* testbench/proc16Tb.sv */
// proc16 testbench
module proc16Tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int dw         = proc16Pkg::dataWidth;
    localparam int numRows    = 16;
    localparam int cycleLimit = numRows * 60; // Worst row is well under 60 cycles

    localparam logic [1:0] kindAlu   = 2'd0;
    localparam logic [1:0] kindAddi  = 2'd1;
    localparam logic [1:0] kindTrap  = 2'd2;     // ALU op then an illegal opcode
    localparam logic [4:0] opIllegal = 5'b11111; // Not in the opcode set

    typedef struct {
        string         name;
        logic [1:0]    kind;
        logic [4:0]    sel;      // Funct in low bits, or ADDI immediate
        logic [dw-1:0] a;        // Data address 0
        logic [dw-1:0] b;        // Data address 1
        logic [dw-1:0] expected; // Data address 2 after the run
    } rowT;

    logic          clk;
    logic          reset;
    logic          run;
    logic          loadWrite;
    logic          loadSel;
    logic [7:0]    loadAddr;
    logic [dw-1:0] loadData;
    logic [7:0]    dbgAddr;
    logic [dw-1:0] dbgData;
    logic          halted;
    logic          err;

    rowT              rows [numRows];
    int               fill;
    int               cycles = 0;
    logic [31:0]      lfsrState = 32'ha533d3dc;
    proc16Pkg::instrT prog [$]; // Program of the current row

    proc16 #(.imemDepth(256), .dmemDepth(256)) i_proc16 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    // Run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("ERRORS FOUND");
            $fatal(1, "timeout waiting for halted");
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] bits;
        logic        lsb;
        int          k;
        bits = '0;
        for (k = 0; k < count; k++) begin
            lsb       = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (lsb) lfsrState = lfsrState ^ 32'hA3000000;
            bits = {bits[30:0], lsb};
        end
        return bits;
    endfunction

    // Expected ALU result, wraps modulo 2^16
    function automatic logic [dw-1:0] refResult(input logic [1:0] kind, input logic [4:0] sel,
                                                input logic [dw-1:0] a, input logic [dw-1:0] b);
        logic [dw-1:0] immWord;
        immWord = dw'($signed(sel)); // Signed 5-bit immediate
        if (kind == kindAddi) return a + immWord;
        case (sel[1:0])
            proc16Pkg::fnSub: return a - b;
            proc16Pkg::fnAnd: return a & b;
            proc16Pkg::fnXor: return a ^ b;
            default:          return a + b;
        endcase
    endfunction

    function automatic proc16Pkg::instrT encR(input logic [1:0] funct, input logic [2:0] rs,
                                             input logic [2:0] rt, input logic [2:0] rd);
        proc16Pkg::instrT w;
        w.r.opcode = proc16Pkg::opAlu;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.funct  = funct;
        return w;
    endfunction

    function automatic proc16Pkg::instrT encI(input logic [4:0] op, input logic [2:0] rs,
                                             input logic [2:0] rd, input logic [4:0] imm);
        proc16Pkg::instrT w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rd     = rd; // Store source on ST
        w.i.imm    = imm;
        return w;
    endfunction

    task automatic tick();
        @(posedge clk);
        #2; // Drive just after the edge
    endtask

    task automatic resetDut();
        reset = 1'b1;
        repeat (8) tick();
        reset = 1'b0;
    endtask

    task automatic loadWord(input logic sel, input logic [7:0] addr, input logic [dw-1:0] data);
        loadWrite = 1'b1;
        loadSel   = sel;
        loadAddr  = addr;
        loadData  = data;
        tick();
        loadWrite = 1'b0;
    endtask

    task automatic checkWord(input string name, input logic [dw-1:0] expected,
                             input logic [dw-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "%s word mismatch", name);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s expected %b actual %b", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "%s flag mismatch", name);
        end
    endtask

    task automatic addRow(input string name, input logic [1:0] kind, input logic [4:0] sel,
                          input logic [dw-1:0] a, input logic [dw-1:0] b,
                          input logic [dw-1:0] expected);
        rows[fill] = '{name, kind, sel, a, b, expected};
        fill = fill + 1;
    endtask

    // r0 is never written, its power-up zero is the base register
    task automatic buildProgram(input rowT r);
        proc16Pkg::instrT nop;
        nop  = encI(proc16Pkg::opNop, 3'd0, 3'd0, 5'd0);
        prog = {};
        prog.push_back(encI(proc16Pkg::opLd, 3'd0, 3'd1, 5'd0)); // r1 = a
        prog.push_back(encI(proc16Pkg::opLd, 3'd0, 3'd2, 5'd1)); // r2 = b
        prog.push_back(nop);
        prog.push_back(nop); // r2 three slots ahead of its reader
        if (r.kind == kindAddi) prog.push_back(encI(proc16Pkg::opAddi, 3'd1, 3'd3, r.sel));
        else prog.push_back(encR(r.sel[1:0], 3'd1, 3'd2, 3'd3));
        prog.push_back(nop);
        prog.push_back(nop);
        prog.push_back(encI(proc16Pkg::opSt, 3'd0, 3'd3, 5'd2)); // Reads r3 exactly 3 slots on
        if (r.kind == kindTrap) begin
            prog.push_back(encI(opIllegal, 3'd0, 3'd0, 5'd0));
            prog.push_back(encI(proc16Pkg::opSt, 3'd0, 3'd1, 5'd2)); // Must never land
        end
        prog.push_back(encI(proc16Pkg::opHalt, 3'd0, 3'd0, 5'd0));
    endtask

    task automatic runRow(input rowT r);
        int k;
        resetDut();
        checkFlag({r.name, " halted at reset"}, 1'b0, halted);
        checkFlag({r.name, " err at reset"}, 1'b0, err);
        loadWord(1'b1, 8'd0, r.a);
        loadWord(1'b1, 8'd1, r.b);
        loadWord(1'b1, 8'd2, ~r.expected); // Stale result cannot match
        buildProgram(r);
        for (k = 0; k < prog.size(); k++) begin
            loadWord(1'b0, 8'(k), prog[k]);
        end
        run = 1'b1;
        dbgAddr = 8'd0;
        loadWord(1'b1, 8'd0, ~r.a); // Loader locked out while running
        while (!halted) tick();
        run = 1'b0;
        dbgAddr = 8'd2;
        #1;
        checkWord(r.name, r.expected, dbgData);
        dbgAddr = 8'd0;
        #1;
        checkWord({r.name, " addr0"}, r.a, dbgData); // Operands untouched
        dbgAddr = 8'd1;
        #1;
        checkWord({r.name, " addr1"}, r.b, dbgData);
        checkFlag({r.name, " err"}, r.kind == kindTrap, err);
    endtask

    initial begin
        int            k;
        logic [31:0]   word;
        logic [1:0]    kind;
        logic [4:0]    sel;
        logic [dw-1:0] a;
        logic [dw-1:0] b;
        reset     = 1'b1;
        run       = 1'b0;
        loadWrite = 1'b0;
        loadSel   = 1'b0;
        loadAddr  = 8'd0;
        loadData  = '0;
        dbgAddr   = 8'd0;
        fill      = 0;

        // Hand-computed rows
        addRow("add", kindAlu, 5'(proc16Pkg::fnAdd), 16'h1234, 16'h0FF0, 16'h2224);
        addRow("add_wrap", kindAlu, 5'(proc16Pkg::fnAdd), 16'hFFFF, 16'h0002, 16'h0001);
        addRow("sub", kindAlu, 5'(proc16Pkg::fnSub), 16'h0005, 16'h0007, 16'hFFFE);
        addRow("and", kindAlu, 5'(proc16Pkg::fnAnd), 16'hF0F0, 16'h3C3C, 16'h3030);
        addRow("xor", kindAlu, 5'(proc16Pkg::fnXor), 16'hF0F0, 16'h3C3C, 16'hCCCC);
        addRow("addi_m1", kindAddi, 5'h1F, 16'h0100, 16'h5A5A, 16'h00FF);   // a minus 1
        addRow("addi_p7", kindAddi, 5'h07, 16'hFFFC, 16'hA5A5, 16'h0003);
        addRow("illegal", kindTrap, 5'(proc16Pkg::fnAdd), 16'h0003, 16'h0004, 16'h0007);

        // Random rows, ALU or ADDI
        for (k = 0; k < numRows - 8; k++) begin
            word = randBits(1);
            if (word[0]) begin
                kind = kindAddi;
                word = randBits(5);
                sel  = word[4:0];
            end else begin
                kind = kindAlu;
                word = randBits(2);
                sel  = {3'b000, word[1:0]};
            end
            word = randBits(16);
            a    = word[15:0];
            word = randBits(16);
            b    = word[15:0];
            addRow($sformatf("rand%0d", k), kind, sel, a, b, refResult(kind, sel, a, b));
        end

        for (k = 0; k < numRows; k++) begin
            runRow(rows[k]);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* testbench/proc16_assert.sv */
// Memory stage and halt checks
module proc16_assert (
    input logic                            clk,
    input logic                            reset,
    input logic                            run,
    input logic                            halted,
    input logic                            memValid,
    input logic                            memWriteOut,
    input logic                            loadWrite,
    input logic                            loadSel,
    input logic [7:0]                      loadAddr,
    input logic [7:0]                      dbgAddr,
    input logic [proc16Pkg::dataWidth-1:0] dbgData
);
    timeunit 1ns;
    timeprecision 1ps;

    // Sticky until the next reset
    haltedSticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else $error("halted fell without reset");

    // Pipe has drained once halted is up
    noStoreHalted: assert property (@(posedge clk) disable iff (reset)
        halted |-> !(memValid && memWriteOut))
        else $error("data memory store while halted");

    // Loader strobe during a run leaves the watched word alone
    loadIdle: assert property (@(posedge clk)
        (loadWrite && loadSel && run && loadAddr == dbgAddr && !(memValid && memWriteOut))
        |=> (!$stable(dbgAddr) || $stable(dbgData)))
        else $error("data memory load accepted while running");

endmodule

bind memory proc16_assert memoryChecks (
    .clk(clk),
    .reset(reset),
    .run(run),
    .halted(halted),
    .memValid(memValid),
    .memWriteOut(memWriteOut),
    .loadWrite(loadWrite),
    .loadSel(loadSel),
    .loadAddr(loadAddr),
    .dbgAddr(dbgAddr),
    .dbgData(dbgData)
);
